//--- verilog/gfx_blend_pkg.sv
// Blend stage types: colour depths, coordinate width, fragment, pixel, channel and target structs
`default_nettype none

package gfx_blend_pkg;

  // Width of x, y and z everywhere in the pixel pipeline
  localparam int unsigned POINT_W = 16;

  // Framebuffer colour depth select
  typedef enum logic [2:0] {
    BPP6,
    BPP8,
    BPP9,
    BPP12,
    BPP15,
    BPP16,
    BPP24,
    BPP32
  } color_depth_e;

  // Fragment from the rasterizer
  typedef struct packed {
    logic [POINT_W-1:0]        x;
    logic [POINT_W-1:0]        y;
    logic signed [POINT_W-1:0] z;
    // Packed red high, right-aligned
    logic [31:0]               color;
    // Per-pixel alpha
    logic [7:0]                alpha;
  } fragment_t;

  // Pixel handed on to the render stage
  typedef struct packed {
    logic [POINT_W-1:0]        x;
    logic [POINT_W-1:0]        y;
    logic signed [POINT_W-1:0] z;
    logic [31:0]               color;
  } pixel_t;

  // Raw channel values, zero-extended to a byte
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // Static render target setup
  typedef struct packed {
    logic [31:0]        base;
    logic [POINT_W-1:0] width;
    color_depth_e       depth;
  } target_cfg_t;

  // Storage size of one pixel in memory
  function automatic logic [5:0] bits_per_pixel(input color_depth_e depth);
    case (depth)
      BPP6:    return 6'd6;
      BPP8:    return 6'd8;
      BPP9:    return 6'd9;
      BPP12:   return 6'd12;
      BPP15:   return 6'd15;
      BPP16:   return 6'd16;
      BPP24:   return 6'd24;
      default: return 6'd32;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- verilog/gfx_address_calc.sv
// Strip address and first/last bit position of a pixel in the framebuffer
`default_nettype none

module gfx_address_calc (
  input  wire gfx_blend_pkg::target_cfg_t     cfg_i,
  input  wire logic [gfx_blend_pkg::POINT_W-1:0] x_i,
  input  wire logic [gfx_blend_pkg::POINT_W-1:0] y_i,
  output logic [31:0]                         addr_o,
  output logic [6:0]                          mb_o,
  output logic [6:0]                          me_o
);
  import gfx_blend_pkg::*;

  // Reciprocal of pixels per strip, ceil(2^37 / P)
  // Error term stays below 2^5 so the quotient is exact for any 32-bit index
  localparam int unsigned RECIP_SHIFT = 37;
  localparam logic [37:0] RECIP_ONE   = 38'd1 << RECIP_SHIFT;
  localparam logic [35:0] RECIP_P21   = 36'((RECIP_ONE + 38'd20) / 38'd21);
  localparam logic [35:0] RECIP_P16   = 36'((RECIP_ONE + 38'd15) / 38'd16);
  localparam logic [35:0] RECIP_P14   = 36'((RECIP_ONE + 38'd13) / 38'd14);
  localparam logic [35:0] RECIP_P10   = 36'((RECIP_ONE + 38'd9) / 38'd10);
  localparam logic [35:0] RECIP_P8    = 36'((RECIP_ONE + 38'd7) / 38'd8);
  localparam logic [35:0] RECIP_P5    = 36'((RECIP_ONE + 38'd4) / 38'd5);
  localparam logic [35:0] RECIP_P4    = 36'((RECIP_ONE + 38'd3) / 38'd4);

  logic [31:0] index;
  logic [5:0]  bpp;
  logic [4:0]  ppb;
  logic [35:0] recip;
  logic [66:0] prod;
  logic [29:0] strip;
  logic [4:0]  slot;

  // Linear pixel index, y * width + x
  assign index = 32'(y_i) * 32'(cfg_i.width) + 32'(x_i);
  assign bpp   = bits_per_pixel(cfg_i.depth);

  // Pixels per 128-bit strip
  always_comb
  begin
    case (cfg_i.depth)
      BPP6:           ppb = 5'd21;
      BPP8:           ppb = 5'd16;
      BPP9:           ppb = 5'd14;
      BPP12:          ppb = 5'd10;
      BPP15, BPP16:   ppb = 5'd8;
      BPP24:          ppb = 5'd5;
      default:        ppb = 5'd4;
    endcase
  end

  always_comb
  begin
    case (ppb)
      5'd21:   recip = RECIP_P21;
      5'd16:   recip = RECIP_P16;
      5'd14:   recip = RECIP_P14;
      5'd10:   recip = RECIP_P10;
      5'd8:    recip = RECIP_P8;
      5'd5:    recip = RECIP_P5;
      default: recip = RECIP_P4;
    endcase
  end

  // Strip number via multiply-shift
  assign prod  = 67'(index) * 67'(recip);
  assign strip = prod[66:RECIP_SHIFT];

  // Slot of the pixel inside its strip
  assign slot = 5'(index - 32'(strip) * 32'(ppb));

  assign mb_o   = 7'(slot) * 7'(bpp);
  assign me_o   = mb_o + 7'(bpp) - 7'd1;
  // 16 bytes per strip
  assign addr_o = cfg_i.base + (32'(strip) << 4);

endmodule

`default_nettype wire

//--- verilog/gfx_strip_extract.sv
// Selection of one packed pixel out of a 128-bit memory strip
`default_nettype none

module gfx_strip_extract (
  input  wire logic [127:0] strip_i,
  input  wire logic [6:0]   mb_i,
  input  wire logic [6:0]   me_i,
  output logic [31:0]       color_o
);

  logic [31:0] shifted;
  logic [5:0]  field_len;
  logic [31:0] mask;

  // Bring the first pixel bit down to bit 0
  assign shifted = 32'(strip_i >> mb_i);

  // Field is at most 32 bits wide
  assign field_len = 6'(me_i - mb_i) + 6'd1;

  // Full mask for 32 bpp
  always_comb
  begin
    if (field_len[5])
    begin
      mask = '1;
    end
    else
    begin
      mask = (32'd1 << field_len[4:0]) - 32'd1;
    end
  end

  // Bits above the pixel belong to the neighbour
  assign color_o = shifted & mask;

endmodule

`default_nettype wire

//--- verilog/gfx_color_unpack.sv
// Split of a packed colour into raw red, green and blue channels per depth
`default_nettype none

module gfx_color_unpack (
  input  wire gfx_blend_pkg::color_depth_e depth_i,
  input  wire logic [31:0]                 color_i,
  output gfx_blend_pkg::rgb_t              rgb_o
);
  import gfx_blend_pkg::*;

  // Red in the high field, blue in the low field
  // Channels stay raw, no scaling up to 8 bits
  always_comb
  begin
    rgb_o = '0;
    case (depth_i)
      BPP6:
      begin
        rgb_o.r = 8'(color_i[5:4]);
        rgb_o.g = 8'(color_i[3:2]);
        rgb_o.b = 8'(color_i[1:0]);
      end
      // 3/3/2
      BPP8:
      begin
        rgb_o.r = 8'(color_i[7:5]);
        rgb_o.g = 8'(color_i[4:2]);
        rgb_o.b = 8'(color_i[1:0]);
      end
      BPP9:
      begin
        rgb_o.r = 8'(color_i[8:6]);
        rgb_o.g = 8'(color_i[5:3]);
        rgb_o.b = 8'(color_i[2:0]);
      end
      BPP12:
      begin
        rgb_o.r = 8'(color_i[11:8]);
        rgb_o.g = 8'(color_i[7:4]);
        rgb_o.b = 8'(color_i[3:0]);
      end
      BPP15:
      begin
        rgb_o.r = 8'(color_i[14:10]);
        rgb_o.g = 8'(color_i[9:5]);
        rgb_o.b = 8'(color_i[4:0]);
      end
      // 5/6/5
      BPP16:
      begin
        rgb_o.r = 8'(color_i[15:11]);
        rgb_o.g = 8'(color_i[10:5]);
        rgb_o.b = 8'(color_i[4:0]);
      end
      // 24 and 32 bpp share the low three bytes
      default:
      begin
        rgb_o.r = color_i[23:16];
        rgb_o.g = color_i[15:8];
        rgb_o.b = color_i[7:0];
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/gfx_blend_alu.sv
// Per-channel alpha mix of source and target colour with repack to the colour depth
`default_nettype none

module gfx_blend_alu (
  input  wire gfx_blend_pkg::color_depth_e depth_i,
  input  wire logic [31:0]                 src_i,
  input  wire logic [31:0]                 dst_i,
  input  wire logic [7:0]                  alpha_i,
  output logic [31:0]                      color_o
);
  import gfx_blend_pkg::*;

  rgb_t src_rgb;
  rgb_t dst_rgb;
  rgb_t mix_rgb;

  // (s * a + d * (255 - a)) >> 8
  function automatic logic [7:0] mix(input logic [7:0] s, input logic [7:0] d,
                                     input logic [7:0] a);
    logic [15:0] acc;
    acc = s * a + d * (8'hff - a);
    return acc[15:8];
  endfunction

  // Source fragment colour
  gfx_color_unpack u_src_unpack (
    .depth_i (depth_i),
    .color_i (src_i),
    .rgb_o   (src_rgb)
  );

  // Colour read back from the target
  gfx_color_unpack u_dst_unpack (
    .depth_i (depth_i),
    .color_i (dst_i),
    .rgb_o   (dst_rgb)
  );

  assign mix_rgb.r = mix(src_rgb.r, dst_rgb.r, alpha_i);
  assign mix_rgb.g = mix(src_rgb.g, dst_rgb.g, alpha_i);
  assign mix_rgb.b = mix(src_rgb.b, dst_rgb.b, alpha_i);

  // Truncate each channel to its width and repack
  always_comb
  begin
    color_o = '0;
    case (depth_i)
      BPP6:    color_o[5:0]  = {mix_rgb.r[1:0], mix_rgb.g[1:0], mix_rgb.b[1:0]};
      BPP8:    color_o[7:0]  = {mix_rgb.r[2:0], mix_rgb.g[2:0], mix_rgb.b[1:0]};
      BPP9:    color_o[8:0]  = {mix_rgb.r[2:0], mix_rgb.g[2:0], mix_rgb.b[2:0]};
      BPP12:   color_o[11:0] = {mix_rgb.r[3:0], mix_rgb.g[3:0], mix_rgb.b[3:0]};
      BPP15:   color_o[14:0] = {mix_rgb.r[4:0], mix_rgb.g[4:0], mix_rgb.b[4:0]};
      BPP16:   color_o[15:0] = {mix_rgb.r[4:0], mix_rgb.g[5:0], mix_rgb.b[4:0]};
      // 24 and 32 bpp, top byte left at zero
      default: color_o[23:0] = {mix_rgb.r, mix_rgb.g, mix_rgb.b};
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/gfx_blender.sv
// Blend control FSM: passthrough, target read, render write and fragment acknowledge
`default_nettype none

module gfx_blender (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    blend_enable_i,
  input  wire logic [7:0]              global_alpha_i,
  // Fragment side
  input  wire gfx_blend_pkg::fragment_t frag_i,
  input  wire logic                    write_i,
  output logic                         ack_o,
  // Memory reader side
  input  wire logic                    wbm_busy_i,
  input  wire logic                    target_ack_i,
  output logic                         target_request_o,
  // Blend datapath
  input  wire logic [31:0]             blended_color_i,
  output logic [7:0]                   alpha_o,
  // Render side
  output gfx_blend_pkg::pixel_t        pixel_o,
  output logic                         write_o,
  input  wire logic                    ack_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_TARGET_READ,
    ST_WRITE
  } state_e;

  state_e      state_q;
  logic [15:0] alpha_prod;
  logic [7:0]  alpha_q;

  // Per-pixel alpha scaled by the global alpha
  assign alpha_prod = frag_i.alpha * global_alpha_i;
  assign alpha_o    = alpha_q;

  // Combined alpha held for the whole read
  always_ff @(posedge clk_i)
  begin
    if (state_q == ST_IDLE && write_i && blend_enable_i)
    begin
      alpha_q <= alpha_prod[15:8];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q          <= ST_IDLE;
      ack_o            <= 1'b0;
      write_o          <= 1'b0;
      target_request_o <= 1'b0;
      pixel_o          <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          // Ack is a single pulse
          ack_o <= 1'b0;
          if (write_i)
          begin
            if (blend_enable_i)
            begin
              // Request goes out with the alpha latch unless the reader is busy
              if (!wbm_busy_i)
              begin
                target_request_o <= 1'b1;
              end
              state_q <= ST_TARGET_READ;
            end
            else
            begin
              // Fragment forwarded as is without a read
              pixel_o.x     <= frag_i.x;
              pixel_o.y     <= frag_i.y;
              pixel_o.z     <= frag_i.z;
              pixel_o.color <= frag_i.color;
              write_o       <= 1'b1;
              state_q       <= ST_WRITE;
            end
          end
        end

        ST_TARGET_READ:
        begin
          if (target_ack_i)
          begin
            // Strip data valid now so the ALU output is the mixed colour
            pixel_o.x        <= frag_i.x;
            pixel_o.y        <= frag_i.y;
            pixel_o.z        <= frag_i.z;
            pixel_o.color    <= blended_color_i;
            write_o          <= 1'b1;
            target_request_o <= 1'b0;
            state_q          <= ST_WRITE;
          end
          else if (!wbm_busy_i)
          begin
            // Raised only when the reader is free and held until ack
            target_request_o <= 1'b1;
          end
        end

        ST_WRITE:
        begin
          write_o <= 1'b0;
          // Wait on render back-pressure
          if (ack_i)
          begin
            ack_o   <= 1'b1;
            state_q <= ST_IDLE;
          end
        end

        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/gfx_blend_top.sv
// Blend stage top: control FSM, address calc, strip extraction and blend ALU
`default_nettype none

module gfx_blend_top (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  // Static configuration
  input  wire gfx_blend_pkg::target_cfg_t cfg_i,
  input  wire logic                       blend_enable_i,
  input  wire logic [7:0]                 global_alpha_i,
  // Fragment port
  input  wire gfx_blend_pkg::fragment_t   frag_i,
  input  wire logic                       write_i,
  output logic                            ack_o,
  // Target memory read port
  output logic                            target_request_o,
  output logic [31:0]                     target_addr_o,
  input  wire logic                       target_ack_i,
  input  wire logic [127:0]               target_data_i,
  input  wire logic                       wbm_busy_i,
  // Render port
  output gfx_blend_pkg::pixel_t           pixel_o,
  output logic                            write_o,
  input  wire logic                       ack_i
);

  logic [6:0]  mb;
  logic [6:0]  me;
  logic [31:0] dst_color;
  logic [31:0] blended_color;
  logic [7:0]  blend_alpha;

  gfx_blender u_blender (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .blend_enable_i   (blend_enable_i),
    .global_alpha_i   (global_alpha_i),
    .frag_i           (frag_i),
    .write_i          (write_i),
    .ack_o            (ack_o),
    .wbm_busy_i       (wbm_busy_i),
    .target_ack_i     (target_ack_i),
    .target_request_o (target_request_o),
    .blended_color_i  (blended_color),
    .alpha_o          (blend_alpha),
    .pixel_o          (pixel_o),
    .write_o          (write_o),
    .ack_i            (ack_i)
  );

  // Strip address straight from the held fragment coordinates
  gfx_address_calc u_address_calc (
    .cfg_i  (cfg_i),
    .x_i    (frag_i.x),
    .y_i    (frag_i.y),
    .addr_o (target_addr_o),
    .mb_o   (mb),
    .me_o   (me)
  );

  gfx_strip_extract u_strip_extract (
    .strip_i (target_data_i),
    .mb_i    (mb),
    .me_i    (me),
    .color_o (dst_color)
  );

  // Destination from memory, source from the fragment
  gfx_blend_alu u_blend_alu (
    .depth_i (cfg_i.depth),
    .src_i   (frag_i.color),
    .dst_i   (dst_color),
    .alpha_i (blend_alpha),
    .color_o (blended_color)
  );

endmodule

`default_nettype wire

//--- verif/tb_target_mem.sv
// Framebuffer memory model: 256 strips, delayed read answers, random busy
`default_nettype none

module tb_target_mem (
  input  wire logic          clk_i,
  input  wire logic          rst_i,
  input  wire logic          request_i,
  input  wire logic [31:0]   addr_i,
  output logic               ack_o,
  output logic [127:0]       data_o,
  output logic               busy_o
);

  // Indexed by address bits 11:4, loaded by the testbench top
  logic [127:0] strips [256];
  int           delay;

  initial
  begin
    ack_o  = 1'b0;
    data_o = '0;
    busy_o = 1'b0;
    delay  = 0;
    forever
    begin
      @(posedge clk_i);
      #1;
      ack_o  = 1'b0;
      // Reader busy about one cycle in four
      busy_o = ($urandom % 4) == 0;
      if (rst_i)
      begin
        delay = 0;
      end
      else if (delay > 1)
      begin
        delay = delay - 1;
      end
      else if (delay == 1)
      begin
        // Single-cycle ack with the strip
        delay  = 0;
        ack_o  = 1'b1;
        data_o = strips[addr_i[11:4]];
      end
      else if (request_i)
      begin
        // Answer 1 to 5 cycles later
        delay = 1 + int'($urandom % 5);
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_gfx_blend.sv
// Blend stage testbench: clock, reset, random fragments, render responder, reference model
`default_nettype none

module tb_gfx_blend;
  import gfx_blend_pkg::*;

  localparam int NUM_FRAGS   = 400;
  localparam int CYCLE_LIMIT = NUM_FRAGS * 20;

  logic         clk_i;
  logic         rst_i;
  target_cfg_t  cfg;
  logic         blend_enable;
  logic [7:0]   global_alpha;
  fragment_t    frag;
  logic         frag_write;
  logic         frag_ack;
  logic         target_request;
  logic [31:0]  target_addr;
  logic         target_ack;
  logic [127:0] target_data;
  logic         wbm_busy;
  pixel_t       pixel;
  logic         render_write;
  logic         render_ack;

  // Reference copy of the framebuffer
  logic [127:0] ref_mem [256];
  logic [31:0]  exp_addr;
  // Per-fragment event counters that are cleared at each write_i
  int           write_cnt;
  int           ack_cnt;
  int           ack_in_cnt;
  int           req_cnt;
  int           cycle_cnt = 0;
  logic         req_prev  = 1'b0;
  logic         busy_prev = 1'b0;
  // Blend fragment still waiting for its read request
  logic         read_pending = 1'b0;

  gfx_blend_top dut0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .cfg_i            (cfg),
    .blend_enable_i   (blend_enable),
    .global_alpha_i   (global_alpha),
    .frag_i           (frag),
    .write_i          (frag_write),
    .ack_o            (frag_ack),
    .target_request_o (target_request),
    .target_addr_o    (target_addr),
    .target_ack_i     (target_ack),
    .target_data_i    (target_data),
    .wbm_busy_i       (wbm_busy),
    .pixel_o          (pixel),
    .write_o          (render_write),
    .ack_i            (render_ack)
  );

  tb_target_mem mem0 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .request_i (target_request),
    .addr_i    (target_addr),
    .ack_o     (target_ack),
    .data_o    (target_data),
    .busy_o    (wbm_busy)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %0h expected %0h", name, got, exp);
      $display("Some tests failed");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  // Run length guard
  always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $fatal(1, "timeout");
    end
  end

  // Render stage acks 0 to 4 cycles after write_o
  initial
  begin
    int delay;
    render_ack = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (render_ack)
      begin
        render_ack = 1'b0;
      end
      else if (render_write)
      begin
        delay = int'($urandom % 5);
        repeat (delay)
        begin
          @(posedge clk_i);
          #1;
        end
        render_ack = 1'b1;
      end
    end
  end

  // Protocol monitor runs half a cycle away from both edges
  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (target_request && !req_prev)
      begin
        check_value("wbm_busy_i at target_request_o rise", busy_prev, 1'b0);
      end
      // Request may only lag the fragment while the reader is busy
      if (read_pending && !target_request)
      begin
        check_value("wbm_busy_i while target_request_o held off", busy_prev, 1'b1);
      end
      if (target_request)
      begin
        read_pending = 1'b0;
        req_cnt      = req_cnt + 1;
        check_value("target_addr_o", target_addr, exp_addr);
      end
      if (frag_write && blend_enable)
      begin
        read_pending = 1'b1;
      end
      if (render_write)
      begin
        write_cnt = write_cnt + 1;
        check_value("write_o pulses before ack_o", write_cnt, 1);
      end
      if (render_ack)
      begin
        ack_in_cnt = ack_in_cnt + 1;
      end
      if (frag_ack)
      begin
        ack_cnt = ack_cnt + 1;
        check_value("ack_i count at ack_o", ack_in_cnt, 1);
      end
    end
    req_prev  = target_request;
    busy_prev = wbm_busy;
  end

  function automatic int depth_bits(input color_depth_e d);
    case (d)
      BPP6:    return 6;
      BPP8:    return 8;
      BPP9:    return 9;
      BPP12:   return 12;
      BPP15:   return 15;
      BPP16:   return 16;
      BPP24:   return 24;
      default: return 32;
    endcase
  endfunction

  // Channel 0 is blue and 2 is red
  function automatic int channel_width(input color_depth_e d, input int ch);
    case (d)
      BPP6:    return 2;
      BPP8:    return (ch == 0) ? 2 : 3;
      BPP9:    return 3;
      BPP12:   return 4;
      BPP15:   return 5;
      BPP16:   return (ch == 1) ? 6 : 5;
      default: return 8;
    endcase
  endfunction

  // Mix each channel and truncate to its field
  function automatic logic [31:0] model_mix(input color_depth_e d, input logic [31:0] src,
                                            input logic [31:0] dst, input int a);
    logic [31:0] res;
    int          off;
    int          w;
    int          s;
    int          t;
    int          m;
    res = '0;
    off = 0;
    for (int ch = 0; ch < 3; ch++)
    begin
      w   = channel_width(d, ch);
      s   = int'((src >> off) & ((32'd1 << w) - 32'd1));
      t   = int'((dst >> off) & ((32'd1 << w) - 32'd1));
      m   = ((s * a + t * (255 - a)) >> 8) & ((1 << w) - 1);
      res = res | (32'(m) << off);
      off = off + w;
    end
    return res;
  endfunction

  // Expected strip address and render colour
  task automatic predict(input fragment_t f, output logic [31:0] addr,
                         output logic [31:0] color);
    int           bpp;
    int           ppb;
    int           index;
    int           strip;
    int           mb;
    int           a;
    logic [127:0] line;
    logic [31:0]  dst;
    bpp   = depth_bits(cfg.depth);
    ppb   = 128 / bpp;
    index = int'(f.y) * int'(cfg.width) + int'(f.x);
    strip = index / ppb;
    mb    = (index % ppb) * bpp;
    addr  = cfg.base + 32'(strip * 16);
    line  = ref_mem[addr[11:4]];
    dst   = 32'((line >> mb) & ((128'd1 << bpp) - 128'd1));
    a     = (int'(f.alpha) * int'(global_alpha)) >> 8;
    if (blend_enable)
    begin
      color = model_mix(cfg.depth, f.color, dst, a);
    end
    else
    begin
      color = f.color;
    end
  endtask

  task automatic configure(input int depth, input logic enable);
    cfg.depth    = color_depth_e'(depth);
    cfg.width    = 16'(64 + $urandom % 256);
    // Aligned so address bits 11:4 pick the strip
    cfg.base     = $urandom & 32'hffff_f000;
    blend_enable = enable;
  endtask

  // Mode 1 has both alphas full, mode 2 zero pixel alpha and mode 3 zero global alpha
  task automatic send_fragment(input int mode);
    fragment_t   f;
    pixel_t      exp_pix;
    logic [31:0] exp_color;
    f.x          = 16'($urandom % cfg.width);
    f.y          = 16'($urandom % 64);
    f.z          = 16'($urandom);
    f.color      = $urandom;
    f.alpha      = 8'($urandom);
    global_alpha = 8'($urandom);
    case (mode)
      1:
      begin
        f.alpha      = 8'hff;
        global_alpha = 8'hff;
      end
      2:       f.alpha = 8'h00;
      3:       global_alpha = 8'h00;
      default: ;
    endcase
    predict(f, exp_addr, exp_color);
    exp_pix.x     = f.x;
    exp_pix.y     = f.y;
    exp_pix.z     = f.z;
    exp_pix.color = exp_color;
    write_cnt     = 0;
    ack_cnt       = 0;
    ack_in_cnt    = 0;
    req_cnt       = 0;
    frag          = f;
    frag_write    = 1'b1;
    @(posedge clk_i);
    #1;
    frag_write = 1'b0;
    while (!frag_ack)
    begin
      @(posedge clk_i);
      #1;
    end
    // One more cycle so the monitor counts the ack pulse
    @(posedge clk_i);
    #1;
    check_value("write_o count", write_cnt, 1);
    check_value("ack_o count", ack_cnt, 1);
    check_value("target_request_o used", req_cnt != 0, blend_enable);
    check_value("pixel_o", pixel, exp_pix);
  endtask

  initial
  begin
    void'($urandom(32'h9bca7485));
    rst_i        = 1'b1;
    cfg          = '0;
    blend_enable = 1'b0;
    global_alpha = 8'h00;
    frag         = '0;
    frag_write   = 1'b0;
    // Framebuffer contents shared with the memory model
    for (int i = 0; i < 256; i++)
    begin
      ref_mem[i]     = {$urandom, $urandom, $urandom, $urandom};
      mem0.strips[i] = ref_mem[i];
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_value("ack_o after reset", frag_ack, 1'b0);
    check_value("write_o after reset", render_write, 1'b0);
    check_value("target_request_o after reset", target_request, 1'b0);
    check_value("pixel_o after reset", pixel, '0);

    // Passthrough at an arbitrary depth
    configure(int'($urandom % 8), 1'b0);
    repeat (40) send_fragment(0);

    // Blend at every depth with alpha extremes
    for (int d = 0; d < 8; d++)
    begin
      configure(d, 1'b1);
      repeat (40) send_fragment(0);
      for (int k = 0; k < 5; k++)
      begin
        send_fragment(1 + k % 3);
      end
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
verilog/gfx_blend_pkg.sv
verilog/gfx_address_calc.sv
verilog/gfx_strip_extract.sv
verilog/gfx_color_unpack.sv
verilog/gfx_blend_alu.sv
verilog/gfx_blender.sv
verilog/gfx_blend_top.sv
verif/tb_target_mem.sv
verif/tb_gfx_blend.sv

//--- run.sh
#!/bin/sh
# Build and run the blend stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_gfx_blend -f all.f -o sim_blend
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_blend
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
fi
exit $status
